//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) --binary --timing --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/mmu_pkg.sv
package mmu_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int VA_W      = 32;	// virtual address
	localparam int PA_W      = 32;	// physical address
	localparam int PAGE_BITS = 12;	// 4 KiB pages
	localparam int IDX_W     = 10;	// va bits per table level
	localparam int TLB_WAYS  = 4;
	localparam int TLB_SETS  = 16;
	localparam int SET_BITS  = 4;	// va bits just above the offset
	localparam int WAY_BITS  = 2;
	localparam int TAG_W     = 16;	// upper va bits
	localparam int PPN_W     = 20;
	localparam int DATA_W    = 64;	// memory bus
	localparam int ASID_W    = 8;
	localparam int PL_W      = 8;
	localparam int PTE_PAD_W = DATA_W - PPN_W - ASID_W - PL_W - 7;

	// page table entry as it sits in memory
	typedef struct packed {
		logic [PPN_W-1:0]     ppn;
		logic [ASID_W-1:0]    asid;
		logic [PL_W-1:0]      pl;
		logic [PTE_PAD_W-1:0] pad;
		logic                 g;	// global, matches any asid
		logic                 d;	// dirty
		logic                 a;	// accessed
		logic                 c;	// cacheable
		logic                 r;
		logic                 w;
		logic                 x;
	} pte_t;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [PPN_W-1:0]  ppn;
		logic [ASID_W-1:0] asid;
		logic              g;
		logic [PL_W-1:0]   pl;
		logic              d;
		logic              a;
		logic              c;
		logic              r;
		logic              w;
		logic              x;
	} tlb_entry_t;

	typedef enum logic [2:0] {
		WALK_IDLE,
		WALK_RD_L1,
		WALK_RD_L2,
		WALK_WR_PTE,
		WALK_FILL
	} walk_state_t;

	// --------------------
	// physical memory attributes, 16 byte granules
	// --------------------
	localparam int PMA_REGIONS = 8;
	localparam int PMA_W       = PA_W - 4;

	// 0 ram, 1-4 vacant, 5-6 io, 7 rom
	localparam logic [PMA_W-1:0] PMA_LB [PMA_REGIONS] = '{
		28'h0000000, 28'h1000000, 28'hFFFFFFF, 28'hFFFFFFF,
		28'hFFFFFFF, 28'hFFD2000, 28'hFFD0000, 28'hFFFC000
	};
	localparam logic [PMA_W-1:0] PMA_UB [PMA_REGIONS] = '{
		28'h0FFFFFF, 28'hFFCFFFF, 28'hFFFFFFF, 28'hFFFFFFF,
		28'hFFFFFFF, 28'hFFDFFFF, 28'hFFD1FFF, 28'hFFFFFFF
	};
	localparam logic [PMA_REGIONS-1:0] PMA_CACHE = 8'b1000_0001;	// bit n = region n

endpackage

//--- hw/mmu_top.sv
module mmu_top (
	input  logic                        clk_i,
	input  logic                        rst_i,
	// page table base, bit 0 enables paging
	input  logic [mmu_pkg::PA_W-1:0]    ptbr_i,
	// cpu request
	input  logic [mmu_pkg::ASID_W-1:0]  asid_i,
	input  logic [mmu_pkg::PL_W-1:0]    pl_i,
	input  logic [1:0]                  ol_i,
	input  logic                        icl_i,
	input  logic                        cyc_i,
	input  logic                        we_i,
	input  logic [7:0]                  sel_i,
	input  logic [mmu_pkg::VA_W-1:0]    vadr_i,
	input  logic                        invalidate_i,
	input  logic                        invalidate_all_i,
	// translated request
	output logic [mmu_pkg::PA_W-1:0]    padr_o,
	output logic                        cyc_o,
	output logic                        we_o,
	output logic [7:0]                  sel_o,
	output logic                        cac_o,
	output logic                        prv_o,
	output logic                        exv_o,
	output logic                        rdv_o,
	output logic                        wrv_o,
	output logic                        ready_o,
	output logic                        page_fault_o,
	// page table bus
	output logic                        m_cyc_o,
	output logic                        m_we_o,
	output logic [mmu_pkg::PA_W-1:0]    m_adr_o,
	output logic [mmu_pkg::DATA_W-1:0]  m_dat_o,
	input  logic                        m_ack_i,
	input  logic [mmu_pkg::DATA_W-1:0]  m_dat_i
);
	import mmu_pkg::*;

	logic                hit;
	logic [WAY_BITS-1:0] hit_way;
	tlb_entry_t          hit_entry;
	logic [TLB_WAYS-1:0] set_valid;
	logic                pma_cache;
	logic                miss;
	logic                fill;
	logic [WAY_BITS-1:0] fill_way;
	logic [SET_BITS-1:0] fill_set;
	tlb_entry_t          fill_entry;

	tlb_store u_tlb (
		.clk_i, .rst_i, .vadr_i, .asid_i,
		.invalidate_i, .invalidate_all_i,
		.fill_i       (fill),
		.fill_way_i   (fill_way),
		.fill_set_i   (fill_set),
		.fill_entry_i (fill_entry),
		.hit_o        (hit),
		.hit_way_o    (hit_way),
		.hit_entry_o  (hit_entry),
		.set_valid_o  (set_valid)
	);

	pma_table u_pma (
		.vadr_i,
		.cache_o (pma_cache)
	);

	xlate_stage u_xlate (
		.clk_i, .rst_i, .ptbr_i, .vadr_i,
		.pl_i, .ol_i, .icl_i, .cyc_i, .we_i, .sel_i,
		.hit_i       (hit),
		.hit_entry_i (hit_entry),
		.pma_cache_i (pma_cache),
		.padr_o, .cyc_o, .we_o, .sel_o, .cac_o,
		.prv_o, .exv_o, .rdv_o, .wrv_o, .ready_o,
		.miss_o      (miss)
	);

	page_walker u_walker (
		.clk_i, .rst_i, .ptbr_i, .vadr_i, .asid_i, .we_i,
		.miss_i       (miss),
		.hit_i        (hit),
		.hit_way_i    (hit_way),
		.set_valid_i  (set_valid),
		.m_ack_i, .m_dat_i, .m_cyc_o, .m_we_o, .m_adr_o, .m_dat_o,
		.fill_o       (fill),
		.fill_way_o   (fill_way),
		.fill_set_o   (fill_set),
		.fill_entry_o (fill_entry),
		.page_fault_o
	);

endmodule

//--- hw/page_walker.sv
module page_walker (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic [mmu_pkg::PA_W-1:0]      ptbr_i,
	input  logic [mmu_pkg::VA_W-1:0]      vadr_i,
	input  logic [mmu_pkg::ASID_W-1:0]    asid_i,
	input  logic                          we_i,
	input  logic                          miss_i,
	input  logic                          hit_i,
	input  logic [mmu_pkg::WAY_BITS-1:0]  hit_way_i,
	input  logic [mmu_pkg::TLB_WAYS-1:0]  set_valid_i,
	input  logic                          m_ack_i,
	input  logic [mmu_pkg::DATA_W-1:0]    m_dat_i,
	output logic                          m_cyc_o,
	output logic                          m_we_o,
	output logic [mmu_pkg::PA_W-1:0]      m_adr_o,
	output logic [mmu_pkg::DATA_W-1:0]    m_dat_o,
	output logic                          fill_o,
	output logic [mmu_pkg::WAY_BITS-1:0]  fill_way_o,
	output logic [mmu_pkg::SET_BITS-1:0]  fill_set_o,
	output mmu_pkg::tlb_entry_t           fill_entry_o,
	output logic                          page_fault_o
);
	import mmu_pkg::*;

	walk_state_t         state_q;
	logic [VA_W-1:0]     miss_adr_q;	// address being walked
	logic [ASID_W-1:0]   asid_q;
	logic                dbit_q;	// walk was caused by a write
	logic [WAY_BITS-1:0] rr_q;	// replacement counter
	logic [WAY_BITS-1:0] way_q;
	logic [WAY_BITS-1:0] way_c;
	pte_t                pte_in;
	pte_t                pte_q;	// level 2 entry with a/d merged in
	logic                pte_ok;
	logic [PA_W-1:0]     l1_adr;
	logic [PA_W-1:0]     l2_adr;
	logic                bus_go;	// free to start a cycle
	logic                bus_done;	// current cycle acked

	assign pte_in   = m_dat_i;
	assign pte_ok   = pte_in.r | pte_in.w | pte_in.x;
	assign bus_go   = ~m_cyc_o & ~m_ack_i;
	assign bus_done = m_cyc_o & m_ack_i;

	// entry address = frame base + index * 8
	assign l1_adr = {ptbr_i[PA_W-1:PAGE_BITS], {PAGE_BITS{1'b0}}} +
		PA_W'({vadr_i[VA_W-1 -: IDX_W], 3'b000});
	assign l2_adr = {pte_in.ppn, {PAGE_BITS{1'b0}}} +
		PA_W'({miss_adr_q[PAGE_BITS +: IDX_W], 3'b000});

	// --------------------
	// way choice
	// --------------------
	always_comb begin
		way_c = rr_q;
		if (hit_i) begin
			way_c = hit_way_i;	// clean page rewalk replaces its own entry
		end else begin
			for (int w = TLB_WAYS-1; w >= 0; w--) begin
				if (!set_valid_i[w])
					way_c = WAY_BITS'(w);	// lowest empty way
			end
		end
	end

	// --------------------
	// walk fsm
	// --------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q      <= WALK_IDLE;
			m_cyc_o      <= 1'b0;
			m_we_o       <= 1'b0;
			page_fault_o <= 1'b0;
			rr_q         <= '0;
		end else begin
			page_fault_o <= 1'b0;	// single cycle pulse
			case (state_q)
				WALK_IDLE: begin
					if (miss_i) begin
						miss_adr_q <= vadr_i;	// cpu still holds the request
						asid_q     <= asid_i;
						dbit_q     <= we_i;
						way_q      <= way_c;
						rr_q       <= rr_q + 1'b1;	// advances on every miss
						m_adr_o    <= l1_adr;
						state_q    <= WALK_RD_L1;
					end
				end
				WALK_RD_L1: begin
					if (bus_go) begin
						m_cyc_o <= 1'b1;
						m_we_o  <= 1'b0;
					end else if (bus_done) begin
						m_cyc_o <= 1'b0;
						if (pte_ok) begin
							m_adr_o <= l2_adr;
							state_q <= WALK_RD_L2;
						end else begin
							page_fault_o <= 1'b1;	// no level 2 table
							state_q      <= WALK_FILL;
						end
					end
				end
				WALK_RD_L2: begin
					if (bus_go) begin
						m_cyc_o <= 1'b1;
						m_we_o  <= 1'b0;
					end else if (bus_done) begin
						m_cyc_o <= 1'b0;
						if (pte_ok) begin
							pte_q   <= pte_in;
							pte_q.a <= 1'b1;
							pte_q.d <= pte_in.d | dbit_q;	// only ever sets bits
							state_q <= WALK_WR_PTE;	// m_adr_o still points at the entry
						end else begin
							page_fault_o <= 1'b1;
							state_q      <= WALK_FILL;
						end
					end
				end
				WALK_WR_PTE: begin
					if (bus_go) begin
						m_cyc_o <= 1'b1;
						m_we_o  <= 1'b1;
					end else if (bus_done) begin
						m_cyc_o <= 1'b0;
						m_we_o  <= 1'b0;
						state_q <= WALK_FILL;	// tlb written on this edge
					end
				end
				// settle cycle, lets the registered miss catch up before idle
				WALK_FILL: state_q <= WALK_IDLE;
				default:   state_q <= WALK_IDLE;
			endcase
		end
	end

	// --------------------
	// tlb fill
	// --------------------
	assign m_dat_o    = pte_q;	// held for the whole write back
	assign fill_o     = (state_q == WALK_WR_PTE) & bus_done;
	assign fill_way_o = way_q;
	assign fill_set_o = miss_adr_q[PAGE_BITS +: SET_BITS];

	always_comb begin
		fill_entry_o.tag  = miss_adr_q[VA_W-1 -: TAG_W];
		fill_entry_o.ppn  = pte_q.ppn;
		fill_entry_o.asid = asid_q;	// address space that did the walk
		fill_entry_o.g    = pte_q.g;
		fill_entry_o.pl   = pte_q.pl;
		fill_entry_o.d    = pte_q.d;
		fill_entry_o.a    = pte_q.a;
		fill_entry_o.c    = pte_q.c;
		fill_entry_o.r    = pte_q.r;
		fill_entry_o.w    = pte_q.w;
		fill_entry_o.x    = pte_q.x;
	end

endmodule

//--- hw/pma_table.sv
module pma_table (
	input  logic [mmu_pkg::VA_W-1:0] vadr_i,
	output logic                     cache_o
);
	import mmu_pkg::*;

	logic [PMA_W-1:0] blk;	// granule number of the address

	assign blk = vadr_i[VA_W-1 -: PMA_W];

	// --------------------
	// region scan
	// --------------------
	// every region is checked, a later match overrides an earlier one so
	// region 7 (rom) beats the vacant filler regions at the top of memory
	always_comb begin
		cache_o = 1'b0;	// nothing matched, treat as uncached
		for (int n = 0; n < PMA_REGIONS; n++) begin
			if (blk >= PMA_LB[n] && blk <= PMA_UB[n])
				cache_o = PMA_CACHE[n];
		end
	end

endmodule

//--- hw/tlb_store.sv
module tlb_store (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic [mmu_pkg::VA_W-1:0]      vadr_i,
	input  logic [mmu_pkg::ASID_W-1:0]    asid_i,
	input  logic                          invalidate_i,
	input  logic                          invalidate_all_i,
	input  logic                          fill_i,
	input  logic [mmu_pkg::WAY_BITS-1:0]  fill_way_i,
	input  logic [mmu_pkg::SET_BITS-1:0]  fill_set_i,
	input  mmu_pkg::tlb_entry_t           fill_entry_i,
	output logic                          hit_o,
	output logic [mmu_pkg::WAY_BITS-1:0]  hit_way_o,
	output mmu_pkg::tlb_entry_t           hit_entry_o,
	output logic [mmu_pkg::TLB_WAYS-1:0]  set_valid_o
);
	import mmu_pkg::*;

	tlb_entry_t          entry_q [TLB_WAYS][TLB_SETS];	// one entry array per way
	logic [TLB_SETS-1:0] valid_q [TLB_WAYS];	// valid bit per way and set
	logic [SET_BITS-1:0] set;
	logic [TAG_W-1:0]    tag;
	logic [TLB_WAYS-1:0] match;	// tag and address space agree, valid not included

	assign set = vadr_i[PAGE_BITS +: SET_BITS];
	assign tag = vadr_i[VA_W-1 -: TAG_W];

	// --------------------
	// parallel compare
	// --------------------
	always_comb begin
		for (int w = 0; w < TLB_WAYS; w++) begin
			match[w] = (entry_q[w][set].tag == tag) &&
				(entry_q[w][set].g || entry_q[w][set].asid == asid_i);
			set_valid_o[w] = valid_q[w][set];
		end
	end

	// lowest numbered valid match wins
	always_comb begin
		hit_o     = 1'b0;
		hit_way_o = '0;
		for (int w = TLB_WAYS-1; w >= 0; w--) begin
			if (match[w] && valid_q[w][set]) begin
				hit_o     = 1'b1;
				hit_way_o = WAY_BITS'(w);
			end
		end
	end

	assign hit_entry_o = entry_q[hit_way_o][set];	// only meaningful with hit_o

	// --------------------
	// fill and invalidate
	// --------------------
	always_ff @(posedge clk_i) begin
		if (fill_i)
			entry_q[fill_way_i][fill_set_i] <= fill_entry_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int w = 0; w < TLB_WAYS; w++)
				valid_q[w] <= '0;	// nothing cached after reset
		end else begin
			if (fill_i)
				valid_q[fill_way_i][fill_set_i] <= 1'b1;
			// invalidation comes last so it wins over a fill in the same cycle
			for (int w = 0; w < TLB_WAYS; w++) begin
				if (invalidate_all_i)
					valid_q[w] <= '0;
				else if (invalidate_i && match[w])
					valid_q[w][set] <= 1'b0;	// this page in this address space or global
			end
		end
	end

endmodule

//--- hw/xlate_stage.sv
module xlate_stage (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic [mmu_pkg::PA_W-1:0]   ptbr_i,
	input  logic [mmu_pkg::VA_W-1:0]   vadr_i,
	input  logic [mmu_pkg::PL_W-1:0]   pl_i,
	input  logic [1:0]                 ol_i,
	input  logic                       icl_i,
	input  logic                       cyc_i,
	input  logic                       we_i,
	input  logic [7:0]                 sel_i,
	input  logic                       hit_i,
	input  mmu_pkg::tlb_entry_t        hit_entry_i,
	input  logic                       pma_cache_i,
	output logic [mmu_pkg::PA_W-1:0]   padr_o,
	output logic                       cyc_o,
	output logic                       we_o,
	output logic [7:0]                 sel_o,
	output logic                       cac_o,
	output logic                       prv_o,
	output logic                       exv_o,
	output logic                       rdv_o,
	output logic                       wrv_o,
	output logic                       ready_o,
	output logic                       miss_o
);
	import mmu_pkg::*;

	logic            pg_en;	// paging enable from ptbr bit 0
	logic            clean_wr;
	logic            miss_c;
	logic            v_c;	// usable translation this cycle
	logic            pv_c;	// privilege mismatch
	logic            r_c;
	logic            w_c;
	logic            x_c;
	logic            c_c;
	logic            ol_nz;	// level 0 never reports violations
	logic [PA_W-1:0] padr_c;

	assign pg_en    = ptbr_i[0];
	assign clean_wr = we_i & ~hit_entry_i.d;	// dirty bit must reach memory first
	assign miss_c   = pg_en & cyc_i & (~hit_i | clean_wr);
	assign ol_nz    = (ol_i != 2'b00);

	// --------------------
	// translate
	// --------------------
	always_comb begin
		if (!pg_en) begin
			padr_c = vadr_i;	// identity map
			v_c    = 1'b1;
			r_c    = 1'b1;
			w_c    = 1'b1;
			x_c    = 1'b1;
			c_c    = pma_cache_i;	// attributes from the pma regions
			pv_c   = 1'b0;
		end else begin
			padr_c = {hit_entry_i.ppn, vadr_i[PAGE_BITS-1:0]};
			v_c    = hit_i & ~miss_c & (hit_entry_i.r | hit_entry_i.w | hit_entry_i.x);
			r_c    = hit_entry_i.r;
			w_c    = hit_entry_i.w;
			x_c    = hit_entry_i.x;
			c_c    = hit_entry_i.c;
			// fetch needs an exact level unless running at level 0, data may go down only
			pv_c   = icl_i ? (pl_i != hit_entry_i.pl && pl_i != '0) : (pl_i > hit_entry_i.pl);
		end
	end

	// --------------------
	// result registers
	// --------------------
	always_ff @(posedge clk_i) begin
		padr_o <= padr_c;
		sel_o  <= sel_i & {8{~pv_c}};
		cac_o  <= c_c & v_c;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cyc_o  <= 1'b0;
			we_o   <= 1'b0;
			prv_o  <= 1'b0;
			exv_o  <= 1'b0;
			rdv_o  <= 1'b0;
			wrv_o  <= 1'b0;
			miss_o <= 1'b0;
		end else begin
			cyc_o  <= cyc_i & v_c & ~pv_c;
			we_o   <= we_i & v_c & ~pv_c & w_c;	// write only reaches a writable page
			prv_o  <= pv_c & v_c & ol_nz;
			exv_o  <= icl_i & v_c & ~x_c & ol_nz;
			rdv_o  <= ~icl_i & ~we_i & v_c & ~r_c & ol_nz;
			wrv_o  <= ~icl_i & we_i & v_c & ~w_c & ol_nz;
			miss_o <= miss_c;
		end
	end

	assign ready_o = ~miss_o;	// hit, paging off, or idle cpu

endmodule

//--- sim.f
hw/mmu_pkg.sv
hw/pma_table.sv
hw/tlb_store.sv
hw/xlate_stage.sv
hw/page_walker.sv
hw/mmu_top.sv
testbench/pt_memory.sv
testbench/tb_mmu.sv

//--- testbench/pt_memory.sv
module pt_memory (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        m_cyc_i,
	input  logic        m_we_i,
	input  logic [31:0] m_adr_i,
	input  logic [63:0] m_dat_i,
	output logic        m_ack_o,
	output logic [63:0] m_dat_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS = 4096;	// 32 KiB, holds both table levels

	logic [63:0] mem [WORDS];
	logic        wait_q;	// first cycle of the two cycle delay seen
	int          n_cycles;	// acked bus cycles, reads and writes
	int          n_writes;
	logic [31:0] last_wr_adr;
	logic [63:0] last_wr_dat;

	// --------------------
	// preload helpers
	// --------------------
	task automatic clear();
		for (int i = 0; i < WORDS; i++)
			mem[i] = 64'd0;	// all zero reads as an invalid entry
	endtask

	task automatic put(input logic [31:0] adr, input logic [63:0] dat);
		mem[adr[14:3]] = dat;
	endtask

	// responder, ack two cycles after m_cyc_i rises
	always @(posedge clk_i) begin
		if (rst_i) begin
			m_ack_o  <= 1'b0;
			m_dat_o  <= 64'd0;
			wait_q   <= 1'b0;
			n_cycles <= 0;
			n_writes <= 0;
		end else begin
			m_ack_o <= 1'b0;	// single cycle ack
			if (m_cyc_i && !m_ack_o) begin
				if (wait_q) begin
					wait_q   <= 1'b0;
					m_ack_o  <= 1'b1;
					n_cycles <= n_cycles + 1;
					if (m_we_i) begin
						mem[m_adr_i[14:3]] = m_dat_i;
						n_writes           <= n_writes + 1;
						last_wr_adr        <= m_adr_i;	// write-back log
						last_wr_dat        <= m_dat_i;
					end else begin
						m_dat_o <= mem[m_adr_i[14:3]];
					end
				end else begin
					wait_q <= 1'b1;
				end
			end
		end
	end

endmodule

//--- testbench/tb_mmu.sv
module tb_mmu;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NROWS = 21;
	localparam logic [31:0] PTBR_ON = 32'h0000_1001;	// root at 0x1000, paging on

	// one stimulus row, viol is {prv, exv, rdv, wrv}
	typedef struct packed {
		logic [31:0] ptbr;
		logic [31:0] vadr;
		logic        we;
		logic        icl;
		logic [7:0]  pl;
		logic [1:0]  ol;
		logic [7:0]  asid;
		logic [1:0]  inv;	// 0 none, 1 one address, 2 all
		logic [31:0] padr;
		logic        fault;
		logic        cac;
		logic        wen;	// expected we_o
		logic [3:0]  viol;
		logic [1:0]  bus;	// bus cycles the row causes
		logic        d;	// dirty bit of the write-back
	} row_t;

	logic        clk_i, rst_i;
	logic [31:0] ptbr_i, vadr_i;
	logic [7:0]  asid_i, pl_i, sel_i;
	logic [1:0]  ol_i;
	logic        icl_i, cyc_i, we_i, invalidate_i, invalidate_all_i;
	logic [31:0] padr_o, m_adr_o;
	logic        cyc_o, we_o, cac_o, prv_o, exv_o, rdv_o, wrv_o, ready_o, page_fault_o;
	logic [7:0]  sel_o;
	logic        m_cyc_o, m_we_o, m_ack_i;
	logic [63:0] m_dat_o, m_dat_i;

	row_t  rows [NROWS];
	string names [NROWS];

	mmu_top mmu_inst (.*);

	pt_memory pt_mem_inst (
		.clk_i, .rst_i,
		.m_cyc_i (m_cyc_o), .m_we_i (m_we_o), .m_adr_i (m_adr_o), .m_dat_i (m_dat_o),
		.m_ack_o (m_ack_i), .m_dat_o (m_dat_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;	// 10 ns period
	end

	// --------------------
	// helpers
	// --------------------
	// ppn, asid, pl, 21 pad bits, then g d a c r w x
	function automatic logic [63:0] make_pte(input logic [19:0] ppn, input logic [7:0] pl,
		input logic [6:0] flags);
		return {ppn, 8'h00, pl, 21'd0, flags};
	endfunction

	task automatic check(input string name, input string field,
		input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("error %s %s expected %0h actual %0h", name, field, exp, act);
			$display("tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic load_tables();
		pt_mem_inst.clear();
		pt_mem_inst.put(32'h1000, make_pte(20'h2, 8'd0, 7'b0000100));	// l1[0] -> 0x2000
		// l1[1] left zero, invalid level 1
		pt_mem_inst.put(32'h2080, make_pte(20'h345, 8'd3, 7'b0001110));	// c r w
		pt_mem_inst.put(32'h2088, make_pte(20'h346, 8'd3, 7'b0000100));	// read only
		pt_mem_inst.put(32'h2090, make_pte(20'h347, 8'd3, 7'b0001010));	// c w, no read
		pt_mem_inst.put(32'h20a0, make_pte(20'h350, 8'd1, 7'b1001110));	// global
	endtask

	task automatic run_row(input int i);
		row_t        r;
		int          cyc0;
		int          wr0;
		logic [31:0] l2_adr;
		logic [63:0] wb;
		r      = rows[i];
		cyc0   = pt_mem_inst.n_cycles;
		wr0    = pt_mem_inst.n_writes;
		l2_adr = 32'h2000 + {20'd0, r.vadr[21:12], 3'b000};
		if (r.inv != 2'd0) begin	// strobe for one cycle ahead of the request
			vadr_i            = r.vadr;
			asid_i            = r.asid;
			invalidate_i      = (r.inv == 2'd1);
			invalidate_all_i  = (r.inv == 2'd2);
			@(posedge clk_i);
			#1;
			invalidate_i      = 1'b0;
			invalidate_all_i  = 1'b0;
		end
		ptbr_i = r.ptbr;
		vadr_i = r.vadr;
		we_i   = r.we;
		icl_i  = r.icl;
		pl_i   = r.pl;
		ol_i   = r.ol;
		asid_i = r.asid;
		cyc_i  = 1'b1;
		do begin
			@(posedge clk_i);
			#1;
		end while (!ready_o && !page_fault_o);	// watchdog bounds this
		check(names[i], "page_fault", r.fault, page_fault_o);
		// a fault or a privilege violation keeps the cycle off the bus
		check(names[i], "cyc", !r.fault && !r.viol[3], cyc_o);
		if (!r.fault) begin
			check(names[i], "padr", r.padr, padr_o);
			check(names[i], "sel", r.viol[3] ? 8'h00 : sel_i, sel_o);
		end
		check(names[i], "cac", r.cac, cac_o);
		check(names[i], "we", r.wen, we_o);
		check(names[i], "viol", r.viol, {prv_o, exv_o, rdv_o, wrv_o});
		cyc_i = 1'b0;	// release so a faulting walk is not retried
		we_i  = 1'b0;
		repeat (4) @(posedge clk_i);
		#1;
		check(names[i], "bus cycles", r.bus, pt_mem_inst.n_cycles - cyc0);
		if (r.bus == 2'd3) begin
			wb = pt_mem_inst.last_wr_dat;
			check(names[i], "writes", 1, pt_mem_inst.n_writes - wr0);
			check(names[i], "wb adr", l2_adr, pt_mem_inst.last_wr_adr);
			check(names[i], "wb accessed", 1'b1, wb[4]);
			check(names[i], "wb dirty", r.d, wb[5]);
		end else begin
			check(names[i], "writes", 0, pt_mem_inst.n_writes - wr0);	// no write-back
		end
	endtask

	// --------------------
	// stimulus table
	// --------------------
	task automatic build_table();
		//         ptbr     vadr          we icl pl ol asid inv padr     flt cac wen viol bus d
		rows[0]  = '{32'h0, 32'h0000_1230, 0, 0, 0, 1, 0, 0, 32'h0000_1230, 0, 1, 0, 0, 0, 0};
		rows[1]  = '{32'h0, 32'hFFD1_0000, 0, 0, 0, 1, 0, 0, 32'hFFD1_0000, 0, 0, 0, 0, 0, 0};
		rows[2]  = '{32'h0, 32'hFFFC_0010, 0, 0, 0, 1, 0, 0, 32'hFFFC_0010, 0, 1, 0, 0, 0, 0};
		rows[3]  = '{PTBR_ON, 32'h0001_0abc, 0, 0, 3, 1, 0, 0, 32'h0034_5abc, 0, 1, 0, 0, 3, 0};
		rows[4]  = '{PTBR_ON, 32'h0001_0abc, 0, 0, 3, 1, 0, 0, 32'h0034_5abc, 0, 1, 0, 0, 0, 0};
		rows[5]  = '{PTBR_ON, 32'h0001_0abc, 1, 0, 3, 1, 0, 0, 32'h0034_5abc, 0, 1, 1, 0, 3, 1};
		rows[6]  = '{PTBR_ON, 32'h0001_0abc, 1, 0, 3, 1, 0, 0, 32'h0034_5abc, 0, 1, 1, 0, 0, 0};
		rows[7]  = '{PTBR_ON, 32'h0040_0000, 0, 0, 3, 1, 0, 0, 32'h0, 1, 0, 0, 0, 1, 0};
		rows[8]  = '{PTBR_ON, 32'h0040_0000, 0, 0, 3, 1, 0, 0, 32'h0, 1, 0, 0, 0, 1, 0};
		rows[9]  = '{PTBR_ON, 32'h0001_3000, 0, 0, 3, 1, 0, 0, 32'h0, 1, 0, 0, 0, 2, 0};
		rows[10] = '{PTBR_ON, 32'h0001_2008, 0, 0, 3, 1, 0, 0, 32'h0034_7008, 0, 1, 0, 2, 3, 0};
		rows[11] = '{PTBR_ON, 32'h0001_2008, 0, 0, 3, 0, 0, 0, 32'h0034_7008, 0, 1, 0, 0, 0, 0};
		rows[12] = '{PTBR_ON, 32'h0001_1010, 1, 0, 3, 1, 0, 0, 32'h0034_6010, 0, 0, 0, 1, 3, 1};
		rows[13] = '{PTBR_ON, 32'h0001_1010, 1, 0, 3, 0, 0, 0, 32'h0034_6010, 0, 0, 0, 0, 0, 0};
		rows[14] = '{PTBR_ON, 32'h0001_4020, 0, 0, 5, 1, 0, 0, 32'h0035_0020, 0, 1, 0, 8, 3, 0};
		rows[15] = '{PTBR_ON, 32'h0001_4020, 0, 0, 1, 1, 0, 0, 32'h0035_0020, 0, 1, 0, 0, 0, 0};
		rows[16] = '{PTBR_ON, 32'h0001_4020, 0, 0, 1, 1, 7, 0, 32'h0035_0020, 0, 1, 0, 0, 0, 0};
		rows[17] = '{PTBR_ON, 32'h0001_0abc, 0, 0, 3, 1, 0, 1, 32'h0034_5abc, 0, 1, 0, 0, 3, 1};
		rows[18] = '{PTBR_ON, 32'h0001_4020, 0, 0, 1, 1, 0, 2, 32'h0035_0020, 0, 1, 0, 0, 3, 0};
		rows[19] = '{PTBR_ON, 32'h0001_0abc, 0, 0, 3, 1, 0, 0, 32'h0034_5abc, 0, 1, 0, 0, 3, 1};
		rows[20] = '{PTBR_ON, 32'h0001_0abc, 0, 1, 3, 1, 0, 0, 32'h0034_5abc, 0, 1, 0, 4, 0, 0};
		names = '{"off_ram", "off_io", "off_rom", "rd_first", "rd_repeat", "wr_clean",
			"wr_again", "l1_fault", "l1_fault_again", "l2_fault", "rd_noread",
			"rd_noread_ol0", "wr_noperm", "wr_noperm_ol0", "prv_data", "prv_ok",
			"global_asid", "inv_one", "inv_all", "inv_all_other", "fetch_noexec"};
	endtask

	// watchdog, 200 cycles per row
	initial begin
		repeat (NROWS * 200) @(posedge clk_i);
		$display("timeout, the DUT did not answer in time");
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_i            = 1'b1;
		ptbr_i           = 32'd0;
		vadr_i           = 32'd0;
		asid_i           = 8'd0;
		pl_i             = 8'd0;
		ol_i             = 2'd0;
		sel_i            = 8'hFF;	// all lanes
		icl_i            = 1'b0;
		cyc_i            = 1'b0;
		we_i             = 1'b0;
		invalidate_i     = 1'b0;
		invalidate_all_i = 1'b0;
		build_table();
		load_tables();
		repeat (16) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		for (int i = 0; i < NROWS; i++)
			run_row(i);
		$display("all tests passed");
		$finish;
	end

endmodule
